/* datapath_pkg.sv */
// ----------------------------------------------------------
// Shared definitions for the three-stage toy core
// Widths, opcode values, instruction encoding and the
// payload types passed between the stages
// ----------------------------------------------------------

package datapath_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------

  // Register and data width
  localparam int XLEN    = 16;
  // Instruction word width
  localparam int ILEN    = 16;
  // Instruction address width
  localparam int PC_W    = 8;
  // Opcode field width
  localparam int OPC_W   = 4;
  // Register index width and register count
  localparam int REG_W   = 2;
  localparam int NREGS   = 4;
  // Immediate and data address widths
  localparam int IMM_W   = 8;
  localparam int DADDR_W = 8;

  // ----------------------------------------------------------
  // Instruction encoding
  // ----------------------------------------------------------
  // [15:12] opcode
  // [11:10] rd   destination of LI, ADD, SUB
  // [9:8]   rs1  first ALU operand, and the value written by ST
  // [7:6]   rs2  second ALU operand
  // [7:0]   imm  LI value, ST data address, JMP target
  // imm overlaps rs2, no instruction uses both
  // Unknown opcodes execute as NOP

  typedef enum logic [OPC_W-1:0] {
    OP_NOP  = 4'h0,
    OP_LI   = 4'h1,
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h3,
    OP_ST   = 4'h4,
    OP_JMP  = 4'h5,
    OP_HALT = 4'h6
  } opcode_t;

  // Decoded instruction, decode to execute
  typedef struct packed {
    opcode_t          opcode;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [IMM_W-1:0] imm;
  } dec_instr_t;

  // Store queue entry, also the data memory request
  typedef struct packed {
    logic [DADDR_W-1:0] addr;
    logic [XLEN-1:0]    data;
  } store_req_t;

endpackage

/* payload_fifo.sv */
// ----------------------------------------------------------
// Small circular-buffer FIFO with valid/ready on both sides
// Payload type is a parameter and flush empties the buffer
// ----------------------------------------------------------

`timescale 1ns/1ns

module payload_fifo #(
  parameter int  DEPTH = 2,
  parameter type T     = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic flush_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Circular storage
  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push, pop;

  assign in_ready_o  = (cnt_q != CNT_W'(DEPTH));
  assign out_valid_o = (cnt_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  // Flush wins over push and pop
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Write port
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

/* fetch_stage.sv */
// ----------------------------------------------------------
// Fetch stage: PC, instruction memory requests, answer FIFO
// Counts outstanding requests so every answer has a slot,
// and drops stale answers after a flush
// ----------------------------------------------------------

`timescale 1ns/1ns

module fetch_stage import datapath_pkg::*; #(
  parameter int DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_i,
  // Redirect from execute
  input  logic            flush_i,
  input  logic [PC_W-1:0] redirect_pc_i,
  // Instruction memory request
  output logic            mem_valid_o,
  input  logic            mem_ready_i,
  output logic [PC_W-1:0] mem_addr_o,
  // Instruction memory answer
  input  logic            mem_valid_i,
  output logic            mem_ready_o,
  input  logic [ILEN-1:0] mem_instr_i,
  // Toward decode
  output logic            issue_valid_o,
  input  logic            issue_ready_i,
  output logic [ILEN-1:0] issue_instr_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  logic             en_q;
  logic [PC_W-1:0]  pc_q, redir_pc_q;
  logic             redir_pend_q;
  logic [CNT_W-1:0] out_cnt_q, out_cnt_nxt, fifo_cnt_q, drop_cnt_q;
  logic [CNT_W:0]   used;
  logic             req_acc, ans_acc, dropping;
  logic             fifo_in_valid, fifo_in_ready, push, pop;

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------

  // Slots taken, in flight plus buffered
  assign used        = {1'b0, out_cnt_q} + {1'b0, fifo_cnt_q};
  assign mem_valid_o = en_q && (used < (CNT_W + 1)'(DEPTH));
  assign mem_addr_o  = pc_q;
  assign req_acc     = mem_valid_o && mem_ready_i;

  // ----------------------------------------------------------
  // Answer side
  // ----------------------------------------------------------

  // Stale answers are taken and thrown away
  assign dropping      = (drop_cnt_q != '0);
  assign fifo_in_valid = mem_valid_i && !dropping;
  assign mem_ready_o   = dropping || fifo_in_ready;
  assign ans_acc       = mem_valid_i && mem_ready_o;
  assign push          = fifo_in_valid && fifo_in_ready;
  assign pop           = issue_valid_o && issue_ready_i;

  // Outstanding count after this edge
  always_comb begin
    out_cnt_nxt = out_cnt_q;
    if (req_acc) out_cnt_nxt = out_cnt_nxt + CNT_W'(1);
    if (ans_acc) out_cnt_nxt = out_cnt_nxt - CNT_W'(1);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q         <= 1'b0;
      pc_q         <= '0;
      redir_pc_q   <= '0;
      redir_pend_q <= 1'b0;
      out_cnt_q    <= '0;
      fifo_cnt_q   <= '0;
      drop_cnt_q   <= '0;
    end else begin
      en_q      <= 1'b1;
      out_cnt_q <= out_cnt_nxt;
      if (flush_i) begin
        // FIFO empties, everything still in memory is stale
        fifo_cnt_q <= '0;
        drop_cnt_q <= out_cnt_nxt;
        if (mem_valid_o && !mem_ready_i) begin
          // Request on the bus must stay put, redirect afterwards
          redir_pend_q <= 1'b1;
          redir_pc_q   <= redirect_pc_i;
        end else begin
          redir_pend_q <= 1'b0;
          pc_q         <= redirect_pc_i;
        end
      end else begin
        case ({push, pop})
          2'b10:   fifo_cnt_q <= fifo_cnt_q + CNT_W'(1);
          2'b01:   fifo_cnt_q <= fifo_cnt_q - CNT_W'(1);
          default: fifo_cnt_q <= fifo_cnt_q;
        endcase
        // Held request is stale once it goes out
        case ({req_acc && redir_pend_q, ans_acc && dropping})
          2'b10:   drop_cnt_q <= drop_cnt_q + CNT_W'(1);
          2'b01:   drop_cnt_q <= drop_cnt_q - CNT_W'(1);
          default: drop_cnt_q <= drop_cnt_q;
        endcase
        if (req_acc) begin
          pc_q         <= redir_pend_q ? redir_pc_q : pc_q + PC_W'(1);
          redir_pend_q <= 1'b0;
        end
      end
    end
  end

  // Answer buffer toward decode
  payload_fifo #(
    .DEPTH (DEPTH),
    .T     (logic [ILEN-1:0])
  ) u_instr_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (fifo_in_valid),
    .in_ready_o  (fifo_in_ready),
    .in_data_i   (mem_instr_i),
    .out_valid_o (issue_valid_o),
    .out_ready_i (issue_ready_i),
    .out_data_o  (issue_instr_o)
  );

endmodule

/* decode_stage.sv */
// ----------------------------------------------------------
// Decode stage: field split plus one pipeline register
// Unknown opcodes leave here as NOP
// ----------------------------------------------------------

`timescale 1ns/1ns

module decode_stage import datapath_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            flush_i,
  // From fetch
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  logic [ILEN-1:0] in_instr_i,
  // Toward execute
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output dec_instr_t      out_instr_o
);

  logic       valid_q;
  dec_instr_t instr_q;
  dec_instr_t dec;

  // Split an instruction word into its fields
  function automatic dec_instr_t decode(input logic [ILEN-1:0] instr);
    dec_instr_t d;
    case (instr[15:12])
      OP_LI, OP_ADD, OP_SUB, OP_ST, OP_JMP, OP_HALT: d.opcode = opcode_t'(instr[15:12]);
      // Anything else does nothing
      default: d.opcode = OP_NOP;
    endcase
    d.rd  = instr[11:10];
    d.rs1 = instr[9:8];
    d.rs2 = instr[7:6];
    d.imm = instr[7:0];
    return d;
  endfunction

  assign dec = decode(in_instr_i);

  // Free slot, or slot drained this cycle
  assign in_ready_o  = !valid_q || out_ready_i;
  assign out_valid_o = valid_q;
  assign out_instr_o = instr_q;

  // Valid flag
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload, loaded on every accepted word
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      instr_q <= dec;
    end
  end

endmodule

/* exec_stage.sv */
// ----------------------------------------------------------
// Execute stage: register file, ALU, jumps, halt and the
// store queue toward data memory
// ----------------------------------------------------------

`timescale 1ns/1ns

module exec_stage import datapath_pkg::*; #(
  parameter int DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_i,
  // From decode
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  dec_instr_t      in_instr_i,
  // Redirect toward fetch and decode
  output logic            flush_o,
  output logic [PC_W-1:0] redirect_pc_o,
  output logic            halt_o,
  // Data memory request
  output logic            mem_valid_o,
  input  logic            mem_ready_i,
  output store_req_t      mem_req_o
);

  logic [XLEN-1:0] rf_q [NREGS];
  logic            halt_q;
  logic [XLEN-1:0] src1, src2;
  logic            is_st, fire;
  logic            sq_in_valid, sq_in_ready;
  store_req_t      sq_in_data;

  // ----------------------------------------------------------
  // Issue control
  // ----------------------------------------------------------

  // Operand read
  assign src1 = rf_q[in_instr_i.rs1];
  assign src2 = rf_q[in_instr_i.rs2];

  // Stall only an ST facing a full queue, stop for good after HALT
  assign is_st      = (in_instr_i.opcode == OP_ST);
  assign in_ready_o = !halt_q && (!is_st || sq_in_ready);
  assign fire       = in_valid_i && in_ready_o;

  // Jump resolves here, one-cycle pulse
  assign flush_o       = fire && (in_instr_i.opcode == OP_JMP);
  assign redirect_pc_o = in_instr_i.imm;
  assign halt_o        = halt_q;

  // Store entry
  assign sq_in_valid     = fire && is_st;
  assign sq_in_data.addr = in_instr_i.imm;
  assign sq_in_data.data = src1;

  // ----------------------------------------------------------
  // Register file and halt flag
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NREGS; i++) begin
        rf_q[i] <= '0;
      end
      halt_q <= 1'b0;
    end else if (fire) begin
      case (in_instr_i.opcode)
        // Zero-extended immediate
        OP_LI:   rf_q[in_instr_i.rd] <= {{(XLEN - IMM_W){1'b0}}, in_instr_i.imm};
        // Both wrap at 16 bits
        OP_ADD:  rf_q[in_instr_i.rd] <= src1 + src2;
        OP_SUB:  rf_q[in_instr_i.rd] <= src1 - src2;
        OP_HALT: halt_q <= 1'b1;
        // ST and JMP act through the queue and flush
        default: ;
      endcase
    end
  end

  // Store queue, keeps draining after HALT
  payload_fifo #(
    .DEPTH (DEPTH),
    .T     (store_req_t)
  ) u_store_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (1'b0),
    .in_valid_i  (sq_in_valid),
    .in_ready_o  (sq_in_ready),
    .in_data_i   (sq_in_data),
    .out_valid_o (mem_valid_o),
    .out_ready_i (mem_ready_i),
    .out_data_o  (mem_req_o)
  );

endmodule

/* datapath.sv */
// ----------------------------------------------------------
// Core datapath top level
// Fetch, decode and execute stages between the instruction
// and data memory ports
// ----------------------------------------------------------

`timescale 1ns/1ns

module datapath import datapath_pkg::*; #(
  parameter int FETCH_FIFO_DEPTH = 2,
  parameter int STORE_FIFO_DEPTH = 2
) (
  // Clock and reset
  input  logic            clk_i,
  input  logic            rst_i,
  // Status
  output logic            mem_flush_o,
  output logic            halt_o,
  // Instruction memory
  output logic            ins_mem_valid_o,
  input  logic            ins_mem_ready_i,
  output logic [PC_W-1:0] ins_mem_addr_o,
  input  logic            ins_mem_valid_i,
  output logic            ins_mem_ready_o,
  input  logic [ILEN-1:0] ins_mem_instr_i,
  // Data memory, stores only
  output logic            data_mem_valid_o,
  input  logic            data_mem_ready_i,
  output store_req_t      data_mem_req_o
);

  // ----------------------------------------------------------
  // Stage to stage signals
  // ----------------------------------------------------------

  // Fetch to decode
  logic            f_valid;
  logic            d_ready;
  logic [ILEN-1:0] f_instr;
  // Decode to execute
  logic            d_valid;
  logic            x_ready;
  dec_instr_t      d_instr;
  // Jump redirect
  logic            flush;
  logic [PC_W-1:0] redirect_pc;

  fetch_stage #(
    .DEPTH (FETCH_FIFO_DEPTH)
  ) u_fetch_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .flush_i       (flush),
    .redirect_pc_i (redirect_pc),
    .mem_valid_o   (ins_mem_valid_o),
    .mem_ready_i   (ins_mem_ready_i),
    .mem_addr_o    (ins_mem_addr_o),
    .mem_valid_i   (ins_mem_valid_i),
    .mem_ready_o   (ins_mem_ready_o),
    .mem_instr_i   (ins_mem_instr_i),
    .issue_valid_o (f_valid),
    .issue_ready_i (d_ready),
    .issue_instr_o (f_instr)
  );

  decode_stage u_decode_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush),
    .in_valid_i  (f_valid),
    .in_ready_o  (d_ready),
    .in_instr_i  (f_instr),
    .out_valid_o (d_valid),
    .out_ready_i (x_ready),
    .out_instr_o (d_instr)
  );

  exec_stage #(
    .DEPTH (STORE_FIFO_DEPTH)
  ) u_exec_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .in_valid_i    (d_valid),
    .in_ready_o    (x_ready),
    .in_instr_i    (d_instr),
    .flush_o       (flush),
    .redirect_pc_o (redirect_pc),
    .halt_o        (halt_o),
    .mem_valid_o   (data_mem_valid_o),
    .mem_ready_i   (data_mem_ready_i),
    .mem_req_o     (data_mem_req_o)
  );

  // Jump flush seen by the memories
  assign mem_flush_o = flush;

endmodule

/* datapath_asserts.sv */
// ----------------------------------------------------------
// Protocol assertions for the core datapath ports
// Request hold, single-cycle flush, sticky halt
// ----------------------------------------------------------

`timescale 1ns/1ns

module datapath_asserts import datapath_pkg::*; (
  input logic            clk_i,
  input logic            rst_i,
  input logic            mem_flush_o,
  input logic            halt_o,
  input logic            ins_mem_valid_o,
  input logic            ins_mem_ready_i,
  input logic [PC_W-1:0] ins_mem_addr_o,
  input logic            data_mem_valid_o,
  input logic            data_mem_ready_i,
  input store_req_t      data_mem_req_o
);

  // Failure count
  int fail_cnt = 0;

  // Instruction request held until accepted
  ins_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    ins_mem_valid_o && !ins_mem_ready_i |=> ins_mem_valid_o && $stable(ins_mem_addr_o)
  ) else begin
    fail_cnt++;
    $error("instruction request dropped or changed before acceptance");
  end

  // Store request held until accepted
  data_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    data_mem_valid_o && !data_mem_ready_i |=> data_mem_valid_o && $stable(data_mem_req_o)
  ) else begin
    fail_cnt++;
    $error("store request dropped or changed before acceptance");
  end

  // Flush is a one-cycle pulse
  flush_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_flush_o |=> !mem_flush_o
  ) else begin
    fail_cnt++;
    $error("flush high for two cycles in a row");
  end

  // Only reset clears halt
  halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_o |=> halt_o
  ) else begin
    fail_cnt++;
    $error("halt fell without a reset");
  end

endmodule

bind datapath datapath_asserts u_datapath_asserts (.*);

/* tb_datapath.sv */
// ----------------------------------------------------------
// Testbench for the three-stage core datapath
// Program table, instruction and data memory emulators,
// store scoreboard and watchdog
// ----------------------------------------------------------

`timescale 1ns/1ns

module tb_datapath import datapath_pkg::*; ();

  localparam int NPROG          = 4;
  localparam int MAXLEN         = 16;
  localparam int MAXST          = 8;
  // Budget per program, reset included
  localparam int PROG_BUDGET_NS = 2000;

  // DUT ports
  logic               clk_i            = 1'b0;
  logic               rst_i            = 1'b1;
  logic               mem_flush_o;
  logic               halt_o;
  logic               ins_mem_valid_o;
  logic               ins_mem_ready_i  = 1'b0;
  logic [PC_W-1:0]    ins_mem_addr_o;
  logic               ins_mem_valid_i  = 1'b0;
  logic               ins_mem_ready_o;
  logic [ILEN-1:0]    ins_mem_instr_i  = '0;
  logic               data_mem_valid_o;
  logic               data_mem_ready_i = 1'b0;
  store_req_t         data_mem_req_o;

  // Program table and expected stores
  logic [ILEN-1:0]    prog [NPROG][MAXLEN];
  int                 prog_len [NPROG];
  logic [DADDR_W-1:0] exp_addr [NPROG][MAXST];
  logic [XLEN-1:0]    exp_data [NPROG][MAXST];
  int                 exp_cnt [NPROG];
  int                 exp_flush [NPROG];

  // Emulator and scoreboard state
  logic [ILEN-1:0]    imem [256];
  logic [ILEN-1:0]    resp_instr_q [$];
  int                 resp_due_q [$];
  logic [31:0]        rng       = 32'd26;
  int                 cyc       = 0;
  int                 cur_prog  = 0;
  int                 st_idx    = 0;
  int                 flush_cnt = 0;
  int                 checks    = 0;
  int                 errors    = 0;

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  datapath #(
    .FETCH_FIFO_DEPTH (2),
    .STORE_FIFO_DEPTH (2)
  ) u_datapath (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .mem_flush_o      (mem_flush_o),
    .halt_o           (halt_o),
    .ins_mem_valid_o  (ins_mem_valid_o),
    .ins_mem_ready_i  (ins_mem_ready_i),
    .ins_mem_addr_o   (ins_mem_addr_o),
    .ins_mem_valid_i  (ins_mem_valid_i),
    .ins_mem_ready_o  (ins_mem_ready_o),
    .ins_mem_instr_i  (ins_mem_instr_i),
    .data_mem_valid_o (data_mem_valid_o),
    .data_mem_ready_i (data_mem_ready_i),
    .data_mem_req_o   (data_mem_req_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic put_instr(input int p, input logic [ILEN-1:0] word);
    prog[p][prog_len[p]] = word;
    prog_len[p]++;
  endtask

  task automatic expect_store(input int p, input logic [DADDR_W-1:0] addr,
                              input logic [XLEN-1:0] data);
    exp_addr[p][exp_cnt[p]] = addr;
    exp_data[p][exp_cnt[p]] = data;
    exp_cnt[p]++;
  endtask

  // ----------------------------------------------------------
  // Programs, hand-encoded, with their store lists
  // ----------------------------------------------------------
  task automatic build_table();
    // Arithmetic and SUB wraparound
    put_instr(0, 16'h1005);  // LI  r0, 0x05
    put_instr(0, 16'h1407);  // LI  r1, 0x07
    put_instr(0, 16'h2840);  // ADD r2, r0, r1
    put_instr(0, 16'h3C40);  // SUB r3, r0, r1
    put_instr(0, 16'h4210);  // ST  r2, 0x10
    put_instr(0, 16'h4311);  // ST  r3, 0x11
    put_instr(0, 16'h23C0);  // ADD r0, r3, r3
    put_instr(0, 16'h4012);  // ST  r0, 0x12
    put_instr(0, 16'hF123);  // unknown opcode, NOP
    put_instr(0, 16'h6000);  // HALT
    expect_store(0, 8'h10, 16'h000C);
    expect_store(0, 8'h11, 16'hFFFE);
    expect_store(0, 8'h12, 16'hFFFC);
    exp_flush[0] = 0;
    // Two forward jumps over dead stores
    put_instr(1, 16'h1021);  // LI  r0, 0x21
    put_instr(1, 16'h4020);  // ST  r0, 0x20
    put_instr(1, 16'h5005);  // JMP 5
    put_instr(1, 16'h402E);  // ST  r0, 0x2E  skipped
    put_instr(1, 16'h402F);  // ST  r0, 0x2F  skipped
    put_instr(1, 16'h1433);  // LI  r1, 0x33
    put_instr(1, 16'h4121);  // ST  r1, 0x21
    put_instr(1, 16'h500A);  // JMP 10
    put_instr(1, 16'h412D);  // ST  r1, 0x2D  skipped
    put_instr(1, 16'h6000);  // HALT skipped
    put_instr(1, 16'h2840);  // ADD r2, r0, r1
    put_instr(1, 16'h4222);  // ST  r2, 0x22
    put_instr(1, 16'h6000);  // HALT
    expect_store(1, 8'h20, 16'h0021);
    expect_store(1, 8'h21, 16'h0033);
    expect_store(1, 8'h22, 16'h0054);
    exp_flush[1] = 2;
    // Store bursts against a slow data memory
    put_instr(2, 16'h1001);  // LI  r0, 1
    put_instr(2, 16'h1402);  // LI  r1, 2
    put_instr(2, 16'h4030);  // ST  r0, 0x30
    put_instr(2, 16'h4131);  // ST  r1, 0x31
    put_instr(2, 16'h2040);  // ADD r0, r0, r1
    put_instr(2, 16'h4032);  // ST  r0, 0x32
    put_instr(2, 16'h4133);  // ST  r1, 0x33
    put_instr(2, 16'h4034);  // ST  r0, 0x34
    put_instr(2, 16'h3500);  // SUB r1, r1, r0
    put_instr(2, 16'h4135);  // ST  r1, 0x35
    put_instr(2, 16'h6000);  // HALT
    expect_store(2, 8'h30, 16'h0001);
    expect_store(2, 8'h31, 16'h0002);
    expect_store(2, 8'h32, 16'h0003);
    expect_store(2, 8'h33, 16'h0002);
    expect_store(2, 8'h34, 16'h0003);
    expect_store(2, 8'h35, 16'hFFFF);
    exp_flush[2] = 0;
    // Jumps while answers are still in flight
    put_instr(3, 16'h5004);  // JMP 4
    put_instr(3, 16'h4040);  // ST  r0, 0x40  skipped
    put_instr(3, 16'h4041);  // ST  r0, 0x41  skipped
    put_instr(3, 16'h6000);  // HALT skipped
    put_instr(3, 16'h1CAB);  // LI  r3, 0xAB
    put_instr(3, 16'h5009);  // JMP 9
    put_instr(3, 16'h4342);  // ST  r3, 0x42  skipped
    put_instr(3, 16'h4343);  // ST  r3, 0x43  skipped
    put_instr(3, 16'h6000);  // HALT skipped
    put_instr(3, 16'h4344);  // ST  r3, 0x44
    put_instr(3, 16'h38C0);  // SUB r2, r0, r3
    put_instr(3, 16'h4245);  // ST  r2, 0x45
    put_instr(3, 16'h6000);  // HALT
    expect_store(3, 8'h44, 16'h00AB);
    expect_store(3, 8'h45, 16'hFF55);
    exp_flush[3] = 2;
  endtask

  // ----------------------------------------------------------
  // Memory emulators
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_i) begin
      resp_instr_q.delete();
      resp_due_q.delete();
      ins_mem_valid_i  <= 1'b0;
      ins_mem_ready_i  <= 1'b0;
      data_mem_ready_i <= 1'b0;
    end else begin
      // Answer taken by the core
      if (ins_mem_valid_i && ins_mem_ready_o) begin
        void'(resp_instr_q.pop_front());
        void'(resp_due_q.pop_front());
      end
      // New request, latency 0 to 3
      if (ins_mem_valid_o && ins_mem_ready_i) begin
        rng = xorshift(rng);
        resp_instr_q.push_back(imem[ins_mem_addr_o]);
        resp_due_q.push_back(cyc + int'(rng[1:0]));
      end
      rng = xorshift(rng);
      ins_mem_ready_i  <= (rng[1:0] != 2'b00);
      data_mem_ready_i <= rng[2];
      // Oldest answer only, in request order
      if (resp_due_q.size() > 0 && resp_due_q[0] <= cyc) begin
        ins_mem_valid_i <= 1'b1;
        ins_mem_instr_i <= resp_instr_q[0];
      end else begin
        ins_mem_valid_i <= 1'b0;
      end
    end
  end

  // Store scoreboard and flush counter
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (mem_flush_o) begin
        flush_cnt++;
      end
      if (data_mem_valid_o && data_mem_ready_i) begin
        checks++;
        assert (st_idx < exp_cnt[cur_prog]) else begin
          errors++;
          $display("Mismatch at %0t ns: program %0d extra store %h to %h", $time,
                   cur_prog, data_mem_req_o.data, data_mem_req_o.addr);
        end
        if (st_idx < exp_cnt[cur_prog]) begin
          assert (data_mem_req_o.addr == exp_addr[cur_prog][st_idx] &&
                  data_mem_req_o.data == exp_data[cur_prog][st_idx]) else begin
            errors++;
            $display("Mismatch at %0t ns: program %0d store %0d got %h:%h, expected %h:%h",
                     $time, cur_prog, st_idx, data_mem_req_o.addr, data_mem_req_o.data,
                     exp_addr[cur_prog][st_idx], exp_data[cur_prog][st_idx]);
          end
        end
        st_idx++;
      end
    end
  end

  // Nothing may be valid while reset holds
  task automatic check_quiet();
    checks++;
    assert (!ins_mem_valid_o && !data_mem_valid_o && !mem_flush_o && !halt_o) else begin
      errors++;
      $display("Mismatch at %0t ns: valid, flush or halt output high in reset", $time);
    end
  endtask

  // ----------------------------------------------------------
  // One program: reset, load, run to halt and drain, compare
  // ----------------------------------------------------------
  task automatic run_program(input int p);
    @(posedge clk_i);
    rst_i <= 1'b1;
    for (int c = 1; c < 16; c++) begin
      @(posedge clk_i);
      if (c == 1) begin
        cur_prog  = p;
        st_idx    = 0;
        flush_cnt = 0;
        // Unused words are NOPs tagged with their address
        for (int a = 0; a < 256; a++) begin
          imem[a] = (a < prog_len[p]) ? prog[p][a] : {8'hF0, 8'(a)};
        end
      end else begin
        check_quiet();
      end
    end
    @(posedge clk_i);
    check_quiet();
    rst_i <= 1'b0;
    while (!(halt_o && !data_mem_valid_o)) begin
      @(posedge clk_i);
    end
    // Quiet window for late stray stores
    repeat (4) @(posedge clk_i);
    checks++;
    assert (st_idx == exp_cnt[p]) else begin
      errors++;
      $display("Mismatch at %0t ns: program %0d made %0d stores, expected %0d",
               $time, p, st_idx, exp_cnt[p]);
    end
    checks++;
    assert (flush_cnt == exp_flush[p]) else begin
      errors++;
      $display("Mismatch at %0t ns: program %0d saw %0d flushes, expected %0d",
               $time, p, flush_cnt, exp_flush[p]);
    end
  endtask

  initial begin
    build_table();
    for (int p = 0; p < NPROG; p++) begin
      run_program(p);
    end
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             u_datapath.u_datapath_asserts.fail_cnt);
    if (errors == 0 && u_datapath.u_datapath_asserts.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NPROG * PROG_BUDGET_NS);
    $display("Timeout: programs did not finish within %0d ns", NPROG * PROG_BUDGET_NS);
    $display("tests failed");
    $finish;
  end

endmodule

/* datapath.f */
datapath_pkg.sv
payload_fifo.sv
fetch_stage.sv
decode_stage.sv
exec_stage.sv
datapath.sv
datapath_asserts.sv
tb_datapath.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_datapath \
  -f datapath.f -o sim_datapath
./obj_dir/sim_datapath +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx "all tests passed" sim.log; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
